// File: common/spiProtocolPkg.sv
/*
 * SPI slave protocol definitions
 * Command codes and field lengths of the slave command frames
 */
`default_nettype none

package spiProtocolPkg;

	// ------------------------------------------------------------------------
	// Command codes
	// ------------------------------------------------------------------------
	// Field widths first, the codes depend on them
	localparam int spiCmdBits = 8;
	localparam int spiAdrsBits = 16;
	localparam int spiDummyBits = 8;
	localparam int spiDataBits = 32;

	// Register write frame
	localparam logic [spiCmdBits-1:0] spiCmdWrite = 8'h02;
	// Register read frame
	localparam logic [spiCmdBits-1:0] spiCmdRead = 8'h03;

	// Master side transfer length
	localparam int spiByteBits = 8;

	// ------------------------------------------------------------------------
	// Frame boundaries in bits, counted from chip select fall
	// ------------------------------------------------------------------------
	// Command plus address
	localparam int spiHeadBits = spiCmdBits + spiAdrsBits;
	// Read data starts after the turnaround bits
	localparam int spiReadHeadBits = spiHeadBits + spiDummyBits;
	localparam int spiWriteFrameBits = spiHeadBits + spiDataBits;
	// Longest frame, sizes the bit counter
	localparam int spiReadFrameBits = spiReadHeadBits + spiDataBits;

endpackage

`default_nettype wire

// File: common/usiBusPkg.sv
/*
 * Usi register bus definitions
 * Data word type and default widths for the bus and the divider
 */
`default_nettype none

package usiBusPkg;

	// Bus word
	localparam int usiDataBits = 32;
	typedef logic [usiDataBits-1:0] usiData_t;

	// Default address width of the register bus
	localparam int usiAdrsDefault = 16;

	// Default width of the SPI clock divider
	localparam int divWidthDefault = 16;

endpackage

`default_nettype wire

// File: filelist.f
common/usiBusPkg.sv
common/spiProtocolPkg.sv
source/ckeGenerator.sv
spiUnit/spiMasterEngine.sv
spiUnit/spiSlaveFrame.sv
spiUnit/spiBusBridge.sv
spiUnit/spiUnit.sv
verification/spiUnitTb.sv

// File: runSim.sh
#!/bin/sh
# Build the SPI unit testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps -Wno-fatal -j 0 \
	--top-module spiUnitTb -f filelist.f -o spiUnitSim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }
./obj_dir/spiUnitSim > sim.log 2>&1 \
	&& grep -q "^Finished with no errors$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// File: source/ckeGenerator.sv
/*
 * Clock enable generator
 * One-cycle enable every div+1 cycles while enabled
 */
`default_nettype none

module ckeGenerator #(
	parameter int pDivBits = usiBusPkg::divWidthDefault
)(
	input wire sysClk,
	input wire arstN,
	input wire en,
	input wire [pDivBits-1:0] div,
	output logic cke
);

	// Divide value, registered copy
	logic [pDivBits-1:0] divReg;
	// Down counter
	logic [pDivBits-1:0] count;

	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			divReg <= '0;
			count <= '0;
			cke <= 1'b0;
		end
		else
		begin
			divReg <= div;
			if (!en)
			begin
				// Idle, counter held at terminal count
				count <= '0;
				cke <= 1'b0;
			end
			else if (count == '0)
			begin
				// Terminal count, reload and pulse
				count <= divReg;
				cke <= 1'b1;
			end
			else
			begin
				count <= count - 1'b1;
				cke <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: spiUnit/spiBusBridge.sv
/*
 * Usi bus bridge
 * One register read or write per request from the frame decoder
 */
`default_nettype none

module spiBusBridge #(
	parameter int pAdrsBits = usiBusPkg::usiAdrsDefault
)(
	input wire sysClk,
	input wire arstN,
	// Decoder handshake
	input wire bReq,
	output logic bAck,
	input wire bWrite,
	input wire [pAdrsBits-1:0] bAdrs,
	input wire usiBusPkg::usiData_t bWd,
	output usiBusPkg::usiData_t bRd,
	// Usi bus
	output logic [pAdrsBits-1:0] usiAdrs,
	output usiBusPkg::usiData_t usiWd,
	output logic usiWe,
	input wire usiBusPkg::usiData_t usiRd
);

	typedef enum logic [2:0] {stIdle, stWrite, stRdAdrs, stRdLatch, stAck} state_t;

	state_t state;
	logic accept;

	// New request, previous ack already low
	assign accept = (state == stIdle) && bReq && !bAck;

	// ------------------------------------------------------------------------
	// Access FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= stIdle;
			bAck <= 1'b0;
			usiWe <= 1'b0;
			usiAdrs <= '0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					if (accept)
					begin
						usiAdrs <= bAdrs;
						if (bWrite)
						begin
							// Single-cycle strobe
							usiWe <= 1'b1;
							state <= stWrite;
						end
						else
						begin
							state <= stRdAdrs;
						end
					end
				end
				stWrite:
				begin
					usiWe <= 1'b0;
					bAck <= 1'b1;
					state <= stAck;
				end
				// Address settles, read data valid next cycle
				stRdAdrs:
				begin
					state <= stRdLatch;
				end
				stRdLatch:
				begin
					bAck <= 1'b1;
					state <= stAck;
				end
				stAck:
				begin
					if (!bReq)
					begin
						bAck <= 1'b0;
						state <= stIdle;
					end
				end
				default:
				begin
					state <= stIdle;
				end
			endcase
		end
	end

	// Write data and captured read word
	always_ff @(posedge sysClk)
	begin
		if (accept)
		begin
			usiWd <= bWd;
		end
		if (state == stRdLatch)
		begin
			bRd <= usiRd;
		end
	end

endmodule

`default_nettype wire

// File: spiUnit/spiMasterEngine.sv
/*
 * SPI master engine, mode 0, one byte per request
 * SCK toggles on each clock enable, interrupt on completion
 */
`default_nettype none

module spiMasterEngine (
	input wire sysClk,
	input wire arstN,
	input wire cke,
	// Host handshake
	input wire mReq,
	input wire [spiProtocolPkg::spiByteBits-1:0] mWd,
	input wire mCs,
	output logic mAck,
	output logic [spiProtocolPkg::spiByteBits-1:0] mRd,
	output logic spiIntr,
	// SPI pins
	output logic spiSckOut,
	output logic spiMosiOut,
	input wire spiMisoIn,
	output logic spiCsOut
);

	import spiProtocolPkg::*;

	// Two SCK edges per bit
	localparam int edgeTotal = 2 * spiByteBits;

	typedef enum logic [1:0] {stIdle, stShift, stDone} state_t;

	state_t state;
	logic [$clog2(edgeTotal)-1:0] edgeCnt;
	logic [spiByteBits-1:0] txReg;
	logic [spiByteBits-1:0] rxReg;
	logic start;

	// Request seen, previous handshake closed
	assign start = (state == stIdle) && mReq && !mAck;

	// ------------------------------------------------------------------------
	// Control FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= stIdle;
			edgeCnt <= '0;
			mAck <= 1'b0;
			spiIntr <= 1'b0;
			spiSckOut <= 1'b0;
			spiMosiOut <= 1'b0;
		end
		else
		begin
			spiIntr <= 1'b0;
			case (state)
				stIdle:
				begin
					if (start)
					begin
						// MSB valid before the first rising edge
						state <= stShift;
						edgeCnt <= '0;
						spiMosiOut <= mWd[spiByteBits-1];
					end
				end
				stShift:
				begin
					if (cke)
					begin
						spiSckOut <= ~spiSckOut;
						edgeCnt <= edgeCnt + 1'b1;
						// Falling phase, next bit out
						if (spiSckOut)
						begin
							spiMosiOut <= txReg[spiByteBits-2];
						end
						// Last falling edge
						if (edgeCnt == edgeTotal - 1)
						begin
							state <= stDone;
							mAck <= 1'b1;
							spiIntr <= 1'b1;
						end
					end
				end
				stDone:
				begin
					// Hold ack until host drops request
					if (!mReq)
					begin
						mAck <= 1'b0;
						state <= stIdle;
					end
				end
				default:
				begin
					state <= stIdle;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Data shifters
	// ------------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (start)
		begin
			txReg <= mWd;
		end
		else if ((state == stShift) && cke)
		begin
			if (spiSckOut)
			begin
				txReg <= {txReg[spiByteBits-2:0], 1'b0};
			end
			else
			begin
				// Rising phase, sample MISO
				rxReg <= {rxReg[spiByteBits-2:0], spiMisoIn};
			end
		end
	end

	// Received byte, stable until the next start
	assign mRd = rxReg;

	// Chip select, active low
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			spiCsOut <= 1'b1;
		end
		else
		begin
			spiCsOut <= ~mCs;
		end
	end

endmodule

`default_nettype wire

// File: spiUnit/spiSlaveFrame.sv
/*
 * SPI slave frame decoder, mode 0
 * Collects command, address and data, requests a bus access,
 * shifts read data back out on MISO
 */
`default_nettype none

module spiSlaveFrame #(
	parameter int pAdrsBits = usiBusPkg::usiAdrsDefault
)(
	input wire sysClk,
	input wire arstN,
	// SPI pins
	input wire spiSckIn,
	input wire spiCsIn,
	input wire spiMosiIn,
	output logic spiMisoOut,
	// Bridge handshake
	output logic bReq,
	input wire bAck,
	output logic bWrite,
	output logic [pAdrsBits-1:0] bAdrs,
	output usiBusPkg::usiData_t bWd,
	input wire usiBusPkg::usiData_t bRd
);

	import spiProtocolPkg::*;
	import usiBusPkg::*;

	// ------------------------------------------------------------------------
	// Pin synchronizer and SCK edge detect
	// ------------------------------------------------------------------------
	// Bit order cs, sck, mosi
	logic [2:0] pinMeta;
	logic [2:0] pinSync;
	logic sckLast;
	logic csS;
	logic sckS;
	logic mosiS;
	logic sckRise;
	logic sckFall;

	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			// Chip select idles high
			pinMeta <= 3'b100;
			pinSync <= 3'b100;
			sckLast <= 1'b0;
		end
		else
		begin
			pinMeta <= {spiCsIn, spiSckIn, spiMosiIn};
			pinSync <= pinMeta;
			sckLast <= pinSync[1];
		end
	end

	assign {csS, sckS, mosiS} = pinSync;
	// Edges only count inside a frame
	assign sckRise = sckS && !sckLast && !csS;
	assign sckFall = !sckS && sckLast && !csS;

	// ------------------------------------------------------------------------
	// Frame tracking
	// ------------------------------------------------------------------------
	logic [$clog2(spiReadFrameBits+1)-1:0] bitCnt;
	// Unknown command, skip to chip select rise
	logic ignore;
	logic readFrame;
	logic reqPend;
	logic misoActive;
	logic [spiDataBits-1:0] shiftIn;
	logic [spiDataBits-1:0] shiftNext;
	logic [spiAdrsBits-1:0] adrsReg;
	usiData_t wdReg;
	usiData_t misoShift;

	// Receive shifter with the incoming bit
	assign shiftNext = {shiftIn[spiDataBits-2:0], mosiS};
	// Read data phase
	assign misoActive = sckFall && readFrame && (bitCnt >= spiReadHeadBits);

	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			bitCnt <= '0;
			ignore <= 1'b0;
			readFrame <= 1'b0;
			reqPend <= 1'b0;
			bReq <= 1'b0;
			bWrite <= 1'b0;
			spiMisoOut <= 1'b0;
		end
		else
		begin
			if (csS)
			begin
				// Frame abort or end
				bitCnt <= '0;
				ignore <= 1'b0;
				readFrame <= 1'b0;
				spiMisoOut <= 1'b0;
			end
			else if (sckRise && !ignore)
			begin
				bitCnt <= bitCnt + 1'b1;
				// Command complete
				if (bitCnt == spiCmdBits - 1)
				begin
					ignore <= (shiftNext[spiCmdBits-1:0] != spiCmdWrite)
						&& (shiftNext[spiCmdBits-1:0] != spiCmdRead);
					readFrame <= (shiftNext[spiCmdBits-1:0] == spiCmdRead);
				end
				// Read request right after the address
				if (readFrame && (bitCnt == spiHeadBits - 1))
				begin
					reqPend <= 1'b1;
					bWrite <= 1'b0;
				end
				// Write request after the last data bit
				if (!readFrame && (bitCnt == spiWriteFrameBits - 1))
				begin
					reqPend <= 1'b1;
					bWrite <= 1'b1;
				end
			end
			else if (misoActive)
			begin
				spiMisoOut <= misoShift[spiDataBits-1];
			end

			// Four-phase request, waits for ack low
			if (bReq && bAck)
			begin
				bReq <= 1'b0;
			end
			else if (reqPend && !bReq && !bAck)
			begin
				bReq <= 1'b1;
				reqPend <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Frame fields and read data shifter
	// ------------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (sckRise)
		begin
			shiftIn <= shiftNext;
			if (bitCnt == spiHeadBits - 1)
			begin
				adrsReg <= shiftNext[spiAdrsBits-1:0];
			end
			if (bitCnt == spiWriteFrameBits - 1)
			begin
				wdReg <= shiftNext;
			end
		end
		// Read word arrives during the dummy bits
		if (bReq && bAck && !bWrite)
		begin
			misoShift <= bRd;
		end
		else if (misoActive)
		begin
			misoShift <= {misoShift[spiDataBits-2:0], 1'b0};
		end
	end

	assign bAdrs = pAdrsBits'(adrsReg);
	assign bWd = wdReg;

endmodule

`default_nettype wire

// File: spiUnit/spiUnit.sv
/*
 * SPI unit top
 * Master engine with host handshake, and slave frame decoder
 * bridged onto the Usi register bus
 */
`default_nettype none

module spiUnit #(
	parameter int pAdrsBits = usiBusPkg::usiAdrsDefault,
	parameter int pDivBits = usiBusPkg::divWidthDefault
)(
	input wire sysClk,
	input wire arstN,
	// Master CSR
	input wire spiEn,
	input wire [pDivBits-1:0] spiDiv,
	input wire mReq,
	input wire [spiProtocolPkg::spiByteBits-1:0] mWd,
	input wire mCs,
	output logic mAck,
	output logic [spiProtocolPkg::spiByteBits-1:0] mRd,
	output logic spiIntr,
	// Master pins
	output logic spiSckOut,
	output logic spiMosiOut,
	input wire spiMisoIn,
	output logic spiCsOut,
	// Slave pins
	input wire spiSckIn,
	input wire spiCsIn,
	input wire spiMosiIn,
	output logic spiMisoOut,
	// Usi bus
	output logic [pAdrsBits-1:0] usiAdrs,
	output usiBusPkg::usiData_t usiWd,
	output logic usiWe,
	input wire usiBusPkg::usiData_t usiRd
);

	import usiBusPkg::*;

	// ------------------------------------------------------------------------
	// SCK rate
	// ------------------------------------------------------------------------
	logic cke;

	ckeGenerator #(
		.pDivBits(pDivBits)
	) spiCkeGen (
		.sysClk(sysClk),
		.arstN(arstN),
		.en(spiEn),
		.div(spiDiv),
		.cke(cke)
	);

	// ------------------------------------------------------------------------
	// Master side
	// ------------------------------------------------------------------------
	spiMasterEngine spiMaster (
		.sysClk(sysClk),
		.arstN(arstN),
		.cke(cke),
		.mReq(mReq),
		.mWd(mWd),
		.mCs(mCs),
		.mAck(mAck),
		.mRd(mRd),
		.spiIntr(spiIntr),
		.spiSckOut(spiSckOut),
		.spiMosiOut(spiMosiOut),
		.spiMisoIn(spiMisoIn),
		.spiCsOut(spiCsOut)
	);

	// ------------------------------------------------------------------------
	// Slave side, frame decoder to bus
	// ------------------------------------------------------------------------
	// Decoder to bridge handshake
	logic bReq;
	logic bAck;
	logic bWrite;
	logic [pAdrsBits-1:0] bAdrs;
	usiData_t bWd;
	usiData_t bRd;

	spiSlaveFrame #(
		.pAdrsBits(pAdrsBits)
	) spiSlave (
		.sysClk(sysClk),
		.arstN(arstN),
		.spiSckIn(spiSckIn),
		.spiCsIn(spiCsIn),
		.spiMosiIn(spiMosiIn),
		.spiMisoOut(spiMisoOut),
		.bReq(bReq),
		.bAck(bAck),
		.bWrite(bWrite),
		.bAdrs(bAdrs),
		.bWd(bWd),
		.bRd(bRd)
	);

	spiBusBridge #(
		.pAdrsBits(pAdrsBits)
	) spiBridge (
		.sysClk(sysClk),
		.arstN(arstN),
		.bReq(bReq),
		.bAck(bAck),
		.bWrite(bWrite),
		.bAdrs(bAdrs),
		.bWd(bWd),
		.bRd(bRd),
		.usiAdrs(usiAdrs),
		.usiWd(usiWd),
		.usiWe(usiWe),
		.usiRd(usiRd)
	);

endmodule

`default_nettype wire

// File: verification/spiUnitStim.txt
// Columns: kind div adrs data expected, all hex words
// Kinds: 0 reset, 1 master byte, 2 divider, 3 write, 4 read, 5 read fill, 6 unknown cmd
00000000 00000000 00000000 00000000 00000000
00000001 00000003 00000000 000000A5 0000003C
00000001 00000000 00000000 0000005A 000000C3
00000002 00000002 00000000 00000096 00000003
00000002 00000005 00000000 0000000F 00000006
00000003 00000000 00001234 DEADBEEF 00000001
00000004 00000000 00001234 00000000 DEADBEEF
00000005 00000000 000000A7 00000000 00000000
00000006 00000000 00001234 000000A5 00000000
00000003 00000000 00000042 0BADF00D 00000001
00000004 00000000 00000042 00000000 0BADF00D
00000004 00000000 00001234 00000000 DEADBEEF
00000005 00000000 0000FFFF 00000000 00000000

// File: verification/spiUnitTb.sv
/*
 * SPI unit testbench
 * Master byte exchange, divider rate and slave register frames,
 * all driven from the stimulus file
 */
`default_nettype none

module spiUnitTb;

	timeunit 1ns;
	timeprecision 1ps;

	import spiProtocolPkg::*;

	// ------------------------------------------------------------------------
	// Stimulus records
	// ------------------------------------------------------------------------
	localparam int recWords = 5;
	localparam int maxRecords = 32;
	// sysClk cycles per external SCK phase, 8 per period
	localparam int sckPhase = 4;

	// Record kinds
	localparam logic [31:0] kindReset = 32'd0;
	localparam logic [31:0] kindMaster = 32'd1;
	localparam logic [31:0] kindDivider = 32'd2;
	localparam logic [31:0] kindWrite = 32'd3;
	localparam logic [31:0] kindReadStim = 32'd4;
	localparam logic [31:0] kindReadFill = 32'd5;
	localparam logic [31:0] kindUnknown = 32'd6;
	localparam logic [31:0] kindEnd = 32'hFFFF_FFFF;

	logic [31:0] stimMem [0:maxRecords*recWords-1];

	// ------------------------------------------------------------------------
	// DUT signals
	// ------------------------------------------------------------------------
	logic sysClk;
	logic arstN;
	logic spiEn;
	logic [15:0] spiDiv;
	logic mReq;
	logic [7:0] mWd;
	logic mCs;
	logic mAck;
	logic [7:0] mRd;
	logic spiIntr;
	logic spiSckOut;
	logic spiMosiOut;
	logic spiMisoIn;
	logic spiCsOut;
	logic spiSckIn;
	logic spiCsIn;
	logic spiMosiIn;
	logic spiMisoOut;
	logic [15:0] usiAdrs;
	logic [31:0] usiWd;
	logic usiWe;
	logic [31:0] usiRd;

	// Bookkeeping
	int errorCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int cycleCount = 0;
	int timeoutCycles = 0;

	spiUnit UUT (
		.sysClk(sysClk),
		.arstN(arstN),
		.spiEn(spiEn),
		.spiDiv(spiDiv),
		.mReq(mReq),
		.mWd(mWd),
		.mCs(mCs),
		.mAck(mAck),
		.mRd(mRd),
		.spiIntr(spiIntr),
		.spiSckOut(spiSckOut),
		.spiMosiOut(spiMosiOut),
		.spiMisoIn(spiMisoIn),
		.spiCsOut(spiCsOut),
		.spiSckIn(spiSckIn),
		.spiCsIn(spiCsIn),
		.spiMosiIn(spiMosiIn),
		.spiMisoOut(spiMisoOut),
		.usiAdrs(usiAdrs),
		.usiWd(usiWd),
		.usiWe(usiWe),
		.usiRd(usiRd)
	);

	// 20 ns period
	initial sysClk = 1'b0;
	always #10 sysClk = ~sysClk;

	// ------------------------------------------------------------------------
	// Usi memory model
	// ------------------------------------------------------------------------
	logic [31:0] usiMem [0:65535];
	int weCount = 0;
	logic [15:0] lastWeAdrs;
	logic [31:0] lastWeWd;

	// Combinational read
	assign usiRd = usiMem[usiAdrs];

	// Writes land on the strobe, last one kept for checks
	always @(posedge sysClk)
	begin
		if (usiWe)
		begin
			usiMem[usiAdrs] <= usiWd;
			weCount <= weCount + 1;
			lastWeAdrs <= usiAdrs;
			lastWeWd <= usiWd;
		end
	end

	// Run limit
	always @(posedge sysClk)
	begin
		cycleCount <= cycleCount + 1;
		if ((timeoutCycles != 0) && (cycleCount >= timeoutCycles))
		begin
			$display("Timeout, the run did not end within %0d cycles", timeoutCycles);
			$display("Finished with errors");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Initial memory word, every address bit matters
	function automatic logic [31:0] fillWord(input logic [15:0] adrs);
		return xorshift32(xorshift32(32'd89393 ^ {adrs, ~adrs}));
	endfunction

	function automatic string recordName(input logic [31:0] kind, input int idx);
		string base;
		case (kind)
			kindReset: base = "reset state";
			kindMaster: base = "master byte";
			kindDivider: base = "divider rate";
			kindWrite: base = "slave write";
			kindReadStim: base = "slave read";
			kindReadFill: base = "slave read initial";
			kindUnknown: base = "unknown command";
			default: base = "invalid record";
		endcase
		return $sformatf("%0d %s", idx, base);
	endfunction

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("Mismatch in %s: expected %0h, actual %0h", what, expected, actual);
			errorCount++;
		end
	endtask

	// One host byte; the slave model echoes echo on MISO
	task automatic masterTransfer(input logic [15:0] div, input logic [7:0] wd,
		input logic [7:0] echo, output logic [7:0] mosiByte, output logic [7:0] rdByte,
		output int intrCount, output int intrNoAck, output int halfMin,
		output int halfMax, output int toggles, output logic csSeenHigh);
		logic [7:0] echoSh;
		logic sckPrev;
		int since;
		// Divider restarts from a cleared counter
		spiEn = 1'b0;
		spiDiv = div;
		mCs = 1'b1;
		mWd = wd;
		echoSh = echo;
		spiMisoIn = echo[7];
		mosiByte = '0;
		intrCount = 0;
		intrNoAck = 0;
		halfMin = 1 << 30;
		halfMax = 0;
		toggles = 0;
		csSeenHigh = 1'b0;
		since = 0;
		repeat (2) @(negedge sysClk);
		spiEn = 1'b1;
		repeat (2) @(negedge sysClk);
		sckPrev = spiSckOut;
		mReq = 1'b1;
		do
		begin
			@(negedge sysClk);
			since++;
			if (spiSckOut != sckPrev)
			begin
				if (toggles > 0)
				begin
					halfMin = (since < halfMin) ? since : halfMin;
					halfMax = (since > halfMax) ? since : halfMax;
				end
				since = 0;
				toggles++;
				// Mode 0, MOSI valid at the rising edge
				if (spiSckOut)
				begin
					mosiByte = {mosiByte[6:0], spiMosiOut};
					// Chip select low while SCK runs
					csSeenHigh = csSeenHigh | spiCsOut;
				end
				else
				begin
					echoSh = {echoSh[6:0], 1'b0};
					spiMisoIn = echoSh[7];
				end
			end
			sckPrev = spiSckOut;
			if (spiIntr)
			begin
				intrCount++;
				if (!mAck)
				begin
					intrNoAck++;
				end
			end
		end
		while (!mAck);
		rdByte = mRd;
		// Close the handshake
		mReq = 1'b0;
		do
		begin
			@(negedge sysClk);
			if (spiIntr)
			begin
				intrCount++;
			end
		end
		while (mAck);
		mCs = 1'b0;
		@(negedge sysClk);
	endtask

	// External SPI master, frame MSB first from bit 63
	task automatic shiftFrame(input logic [63:0] frame, input int nBits,
		output logic [31:0] misoWord);
		int i;
		misoWord = '0;
		spiCsIn = 1'b0;
		repeat (sckPhase) @(negedge sysClk);
		for (i = 0; i < nBits; i++)
		begin
			spiMosiIn = frame[63-i];
			repeat (sckPhase) @(negedge sysClk);
			// MISO sampled at the rising edge
			misoWord = {misoWord[30:0], spiMisoOut};
			spiSckIn = 1'b1;
			repeat (sckPhase) @(negedge sysClk);
			spiSckIn = 1'b0;
		end
		repeat (sckPhase) @(negedge sysClk);
		spiCsIn = 1'b1;
		repeat (sckPhase) @(negedge sysClk);
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial
	begin
		int rec;
		int base;
		int errBefore;
		int weBefore;
		int waitCycles;
		int limit;
		int intrCount;
		int intrNoAck;
		int halfMin;
		int halfMax;
		int toggles;
		logic [31:0] kind;
		logic [31:0] div;
		logic [31:0] adrs;
		logic [31:0] data;
		logic [31:0] expd;
		logic [31:0] misoWord;
		logic [7:0] mosiByte;
		logic [7:0] rdByte;
		logic csSeenHigh;
		string name;

		arstN = 1'b0;
		spiEn = 1'b0;
		spiDiv = '0;
		mReq = 1'b0;
		mWd = '0;
		mCs = 1'b0;
		spiMisoIn = 1'b0;
		spiSckIn = 1'b0;
		spiCsIn = 1'b1;
		spiMosiIn = 1'b0;

		for (int a = 0; a < 65536; a++)
		begin
			usiMem[a] = fillWord(a[15:0]);
		end
		for (int w = 0; w < maxRecords * recWords; w++)
		begin
			stimMem[w] = kindEnd;
		end
		$readmemh("verification/spiUnitStim.txt", stimMem);

		// Limit from byte and frame lengths
		limit = 200;
		for (rec = 0; rec < maxRecords; rec++)
		begin
			kind = stimMem[rec*recWords];
			div = stimMem[rec*recWords+1];
			if (kind == kindEnd)
			begin
				break;
			end
			if ((kind == kindMaster) || (kind == kindDivider))
			begin
				limit += 16 * (int'(div) + 1) + 96;
			end
			else
			begin
				limit += 64 * 2 * sckPhase + 96;
			end
		end
		timeoutCycles = limit;

		// Reset for two cycles
		repeat (2) @(negedge sysClk);
		arstN = 1'b1;
		@(negedge sysClk);

		for (rec = 0; rec < maxRecords; rec++)
		begin
			base = rec * recWords;
			kind = stimMem[base];
			div = stimMem[base+1];
			adrs = stimMem[base+2];
			data = stimMem[base+3];
			expd = stimMem[base+4];
			if (kind == kindEnd)
			begin
				break;
			end
			name = recordName(kind, rec);
			errBefore = errorCount;
			case (kind)
				kindReset:
				begin
					checkValue({name, " mAck"}, 32'd0, {31'd0, mAck});
					checkValue({name, " spiIntr"}, 32'd0, {31'd0, spiIntr});
					checkValue({name, " usiWe"}, 32'd0, {31'd0, usiWe});
					checkValue({name, " spiCsOut"}, 32'd1, {31'd0, spiCsOut});
				end
				kindMaster:
				begin
					masterTransfer(div[15:0], data[7:0], expd[7:0], mosiByte, rdByte,
						intrCount, intrNoAck, halfMin, halfMax, toggles, csSeenHigh);
					checkValue({name, " MOSI byte"}, {24'd0, data[7:0]}, {24'd0, mosiByte});
					checkValue({name, " mRd"}, {24'd0, expd[7:0]}, {24'd0, rdByte});
					checkValue({name, " interrupt count"}, 32'd1, intrCount);
					checkValue({name, " spiCsOut during transfer"}, 32'd0,
						{31'd0, csSeenHigh});
					assert (intrNoAck == 0)
					else
					begin
						$display("%s: spiIntr pulsed while mAck was low", name);
						errorCount++;
					end
				end
				kindDivider:
				begin
					masterTransfer(div[15:0], data[7:0], 8'h00, mosiByte, rdByte,
						intrCount, intrNoAck, halfMin, halfMax, toggles, csSeenHigh);
					checkValue({name, " SCK edges"}, 32'd16, toggles);
					checkValue({name, " shortest half period"}, expd, halfMin);
					checkValue({name, " longest half period"}, expd, halfMax);
				end
				kindWrite:
				begin
					weBefore = weCount;
					shiftFrame({spiCmdWrite, adrs[15:0], data, 8'h00}, 56, misoWord);
					// Wait for the strobe, bounded
					waitCycles = 0;
					while ((weCount == weBefore) && (waitCycles < 32))
					begin
						@(negedge sysClk);
						waitCycles++;
					end
					repeat (8) @(negedge sysClk);
					assert (weCount != weBefore)
					else
					begin
						$display("%s: no write strobe appeared on the Usi bus", name);
						errorCount++;
					end
					checkValue({name, " strobe count"}, expd, weCount - weBefore);
					checkValue({name, " usiAdrs"}, {16'd0, adrs[15:0]}, {16'd0, lastWeAdrs});
					checkValue({name, " usiWd"}, data, lastWeWd);
				end
				kindReadStim, kindReadFill:
				begin
					weBefore = weCount;
					shiftFrame({spiCmdRead, adrs[15:0], 8'h00, 32'h0}, 64, misoWord);
					// Untouched words hold the fill pattern
					if (kind == kindReadFill)
					begin
						expd = fillWord(adrs[15:0]);
					end
					checkValue({name, " MISO word"}, expd, misoWord);
					checkValue({name, " strobe count"}, 32'd0, weCount - weBefore);
				end
				kindUnknown:
				begin
					weBefore = weCount;
					shiftFrame({data[7:0], adrs[15:0], 32'hFFFF_FFFF, 8'h00}, 56, misoWord);
					repeat (16) @(negedge sysClk);
					checkValue({name, " strobe count"}, 32'd0, weCount - weBefore);
				end
				default:
				begin
					$display("Record %0d has an unknown kind %0h", rec, kind);
					errorCount++;
				end
			endcase
			testsRun++;
			if (errorCount == errBefore)
			begin
				$display("Test %s passed", name);
			end
			else
			begin
				$display("Test %s failed with %0d errors", name, errorCount - errBefore);
				testsFailed++;
			end
		end

		$display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0)
		begin
			$display("Finished with no errors");
		end
		else
		begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire
